// File: design/alu_execute.sv
module alu_execute (
    input  rv_core_pkg::word_t pc,
    decode_ctrl_if.exec        ctrl,
    output rv_core_pkg::word_t alu_result,
    output logic               branch_taken,
    output rv_core_pkg::word_t next_pc
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       rs_eq;
    logic       rs_lt;
    logic       rs_ltu;
    word_t      seq_pc;
    word_t      target;

    // operand muxes
    assign op_a = (ctrl.a_sel == A_PC) ? pc : ctrl.rs1_val;

    always_comb begin
        case (ctrl.b_sel)
            B_IMM:   op_b = ctrl.imm;
            B_FOUR:  op_b = word_t'(4);
            default: op_b = ctrl.rs2_val;
        endcase
    end

    // shifts use the low five bits only
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = word_t'($signed(op_a) < $signed(op_b));
            SLTU:    alu_result = word_t'(op_a < op_b);
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = word_t'($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            PASS_B:  alu_result = op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    // branch compare on raw register values
    assign rs_eq  = (ctrl.rs1_val == ctrl.rs2_val);
    assign rs_lt  = ($signed(ctrl.rs1_val) < $signed(ctrl.rs2_val));
    assign rs_ltu = (ctrl.rs1_val < ctrl.rs2_val);

    always_comb begin
        case (ctrl.funct3)
            F3_BEQ:  branch_taken = rs_eq;
            F3_BNE:  branch_taken = !rs_eq;
            F3_BLT:  branch_taken = rs_lt;
            F3_BGE:  branch_taken = !rs_lt;
            F3_BLTU: branch_taken = rs_ltu;
            F3_BGEU: branch_taken = !rs_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    // next pc adder
    assign seq_pc = pc + word_t'(4);

    always_comb begin
        case (ctrl.pc_sel)
            BR:                target = branch_taken ? (pc + ctrl.imm) : seq_pc;
            rv_core_pkg::JAL:  target = pc + ctrl.imm;
            // bit 0 dropped as the ISA asks
            rv_core_pkg::JALR: target = (ctrl.rs1_val + ctrl.imm) & ~word_t'(1);
            default:           target = seq_pc;
        endcase
    end

    // no misaligned traps, so the fetch address is forced to a word
    assign next_pc = target & ~word_t'(3);

endmodule

// File: design/decode_ctrl_if.sv
interface decode_ctrl_if;
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    // alu controls and operands
    alu_op_e alu_op;
    a_sel_e  a_sel;
    b_sel_e  b_sel;
    word_t   imm;
    word_t   rs1_val;
    word_t   rs2_val;
    // branch condition
    funct3_t funct3;
    // next pc and register write
    pc_sel_e  pc_sel;
    reg_idx_t rd;
    logic     reg_wen;

    modport decode (
        output alu_op, a_sel, b_sel, imm, rs1_val, rs2_val,
        output funct3, pc_sel, rd, reg_wen
    );

    modport exec (
        input alu_op, a_sel, b_sel, imm, rs1_val, rs2_val, funct3, pc_sel
    );

    modport result (
        input pc_sel, rd, reg_wen
    );

endinterface

// File: design/instr_decode.sv
module instr_decode (
    input  rv_isa_pkg::instr_t   instr,
    input  rv_core_pkg::word_t   pc,
    output rv_isa_pkg::reg_idx_t rs1_idx,
    output rv_isa_pkg::reg_idx_t rs2_idx,
    input  rv_core_pkg::word_t   rs1_val,
    input  rv_core_pkg::word_t   rs2_val,
    decode_ctrl_if.decode        ctrl
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e opcode;
    funct3_t funct3;
    logic    funct7_alt;
    logic    writes_rd;

    // funct3 plus bit 30 to alu function
    function automatic alu_op_e alu_op_of(input funct3_t f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SRL_SRA: op = alt ? SRA : SRL;
            F3_OR:      op = OR;
            default:    op = AND;
        endcase
        return op;
    endfunction

    // field split
    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];
    assign rs1_idx    = instr[19:15];
    assign rs2_idx    = instr[24:20];

    assign ctrl.rd      = instr[11:7];
    assign ctrl.funct3  = funct3;
    // register values pass straight on to execute
    assign ctrl.rs1_val = rs1_val;
    assign ctrl.rs2_val = rs2_val;

    // immediate by instruction format
    always_comb begin
        case (opcode)
            OP_IMM, rv_isa_pkg::JALR:
                ctrl.imm = {{20{instr[31]}}, instr[31:20]};
            LUI, AUIPC:
                ctrl.imm = {instr[31:12], 12'b0};
            rv_isa_pkg::JAL:
                ctrl.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            BRANCH:
                ctrl.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:
                ctrl.imm = '0;
        endcase
    end

    // control unit
    always_comb begin
        // no-op defaults, only pc+4
        ctrl.alu_op = ADD;
        ctrl.a_sel  = A_RS1;
        ctrl.b_sel  = B_RS2;
        ctrl.pc_sel = SEQ;
        writes_rd   = 1'b0;
        case (opcode)
            OP: begin
                ctrl.alu_op = alu_op_of(funct3, funct7_alt);
                writes_rd   = 1'b1;
            end
            OP_IMM: begin
                // bit 30 only selects SRAI, ADDI has no subtract form
                ctrl.alu_op = alu_op_of(funct3, (funct3 == F3_SRL_SRA) && funct7_alt);
                ctrl.b_sel  = B_IMM;
                writes_rd   = 1'b1;
            end
            LUI: begin
                ctrl.alu_op = PASS_B;
                ctrl.b_sel  = B_IMM;
                writes_rd   = 1'b1;
            end
            AUIPC: begin
                ctrl.a_sel = A_PC;
                ctrl.b_sel = B_IMM;
                writes_rd  = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                // link value pc+4
                ctrl.a_sel  = A_PC;
                ctrl.b_sel  = B_FOUR;
                ctrl.pc_sel = rv_core_pkg::JAL;
                writes_rd   = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                ctrl.a_sel  = A_PC;
                ctrl.b_sel  = B_FOUR;
                ctrl.pc_sel = rv_core_pkg::JALR;
                writes_rd   = 1'b1;
            end
            BRANCH: begin
                ctrl.pc_sel = BR;
            end
            default: begin
                // SYSTEM, FENCE and unknown opcodes fall through as no-ops
            end
        endcase
    end

    // x0 never takes a write
    assign ctrl.reg_wen = writes_rd && (ctrl.rd != '0);

    always_comb begin
        assert final (!(ctrl.reg_wen === 1'b1 && ctrl.rd === '0))
            else $error("reg_wen raised with rd = x0");
        // fetch side keeps the pc word aligned
        assert final ($isunknown(pc) || pc[1:0] == 2'b00)
            else $error("misaligned pc %h at decode", pc);
    end

endmodule

// File: design/pc_writeback.sv
`include "rv_defs.svh"

module pc_writeback (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 imem_req,
    output rv_core_pkg::word_t   imem_addr,
    input  logic                 imem_ack,
    input  rv_isa_pkg::instr_t   imem_instr,
    output rv_isa_pkg::instr_t   instr,
    output rv_core_pkg::word_t   pc,
    decode_ctrl_if.result        ctrl,
    input  rv_core_pkg::word_t   alu_result,
    input  rv_core_pkg::word_t   next_pc,
    output logic                 rf_wen,
    output rv_isa_pkg::reg_idx_t rf_waddr,
    output rv_core_pkg::word_t   rf_wdata,
    output logic                 wb_valid,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output rv_core_pkg::word_t   wb_data,
    output logic                 wb_wen
);
    import rv_core_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;

    // four-phase fetch then one execute cycle
    always_comb begin
        state_next = state;
        case (state)
            IDLE:    state_next = REQ;
            REQ:     if (imem_ack) state_next = RELEASE;
            RELEASE: if (!imem_ack) state_next = EXEC;
            // next request goes out together with wb_valid
            EXEC:    state_next = REQ;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            pc       <= word_t'(`RESET_PC);
            wb_valid <= 1'b0;
        end else begin
            state    <= state_next;
            wb_valid <= (state == EXEC);
            if (state == EXEC) begin
                pc <= next_pc;
            end
        end
    end

    // latch the word on the ack edge
    always_ff @(posedge clk) begin
        if (state == REQ && imem_ack) begin
            instr <= imem_instr;
        end
    end

    // retire record for the observer
    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            wb_rd   <= ctrl.rd;
            wb_data <= alu_result;
            wb_wen  <= ctrl.reg_wen;
        end
    end

    // request follows the state, address is the held pc
    assign imem_req  = (state == REQ);
    assign imem_addr = pc;

    // register file write only in EXEC
    assign rf_wen   = (state == EXEC) && ctrl.reg_wen;
    assign rf_waddr = ctrl.rd;
    assign rf_wdata = alu_result;

    addr_stable_a: assert property (@(posedge clk) disable iff (rst)
        imem_req |=> (!imem_req || $stable(imem_addr)))
        else $error("imem_addr changed during an open request");

    req_after_ack_low_a: assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req) |-> !imem_ack)
        else $error("imem_req raised while imem_ack still high");

endmodule

// File: design/reg_file.sv
`include "rv_defs.svh"

module reg_file (
    input  logic                 clk,
    input  rv_isa_pkg::reg_idx_t raddr_a,
    input  rv_isa_pkg::reg_idx_t raddr_b,
    output rv_core_pkg::word_t   rdata_a,
    output rv_core_pkg::word_t   rdata_b,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_core_pkg::word_t   wdata,
    input  logic                 wen
);
    import rv_core_pkg::*;

    // storage, entry 0 is never written
    word_t regs [0:`REG_NUM-1];

    // single write port
    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    // x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: design/rv_core.sv
module rv_core (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 imem_req,
    output rv_core_pkg::word_t   imem_addr,
    input  logic                 imem_ack,
    input  rv_isa_pkg::instr_t   imem_instr,
    output logic                 wb_valid,
    output logic                 wb_wen,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output rv_core_pkg::word_t   wb_data,
    output rv_core_pkg::word_t   pc
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    // latched instruction and register file paths
    instr_t   instr;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;
    // execute results
    word_t    alu_result;
    word_t    next_pc;
    // register write port
    logic     rf_wen;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    decode_ctrl_if ctrl_if ();

    instr_decode u_decode (
        .instr   (instr),
        .pc      (pc),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ctrl    (ctrl_if.decode)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .raddr_a (rs1_idx),
        .raddr_b (rs2_idx),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .wen     (rf_wen)
    );

    // branch outcome is folded into next_pc inside execute
    alu_execute u_execute (
        .pc           (pc),
        .ctrl         (ctrl_if.exec),
        .alu_result   (alu_result),
        .branch_taken (),
        .next_pc      (next_pc)
    );

    pc_writeback u_writeback (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_instr (imem_instr),
        .instr      (instr),
        .pc         (pc),
        .ctrl       (ctrl_if.result),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .rf_wen     (rf_wen),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_wen     (wb_wen)
    );

endmodule

// File: design/rv_core_pkg.sv
`include "rv_defs.svh"

package rv_core_pkg;

    // data and address word
    typedef logic [`XLEN-1:0] word_t;

    // alu function select
    // PASS_B forwards operand b, used by LUI
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // alu operand a source
    typedef enum logic {
        A_RS1,
        A_PC
    } a_sel_e;

    // alu operand b source
    typedef enum logic [1:0] {
        B_RS2,
        B_IMM,
        B_FOUR
    } b_sel_e;

    // next pc source
    typedef enum logic [1:0] {
        SEQ,
        BR,
        JAL,
        JALR
    } pc_sel_e;

    // fetch and retire sequencing
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        EXEC
    } fetch_state_e;

endpackage

// File: design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// integer register and address width
`define XLEN 32

// architectural register count, x0 included
`define REG_NUM 32

// bits needed to index one register
`define REG_IDX_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: design/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

    // raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // register index, x0 to x31
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // funct3 field
    typedef logic [2:0] funct3_t;

    // major opcodes handled by the core
    // anything else decodes as a no-op
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

// File: src.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/decode_ctrl_if.sv
design/instr_decode.sv
design/reg_file.sv
design/alu_execute.sv
design/pc_writeback.sv
design/rv_core.sv
testbench/tb_clock_gen.sv
testbench/rv_core_tb.sv

// File: testbench/rv_core_tb.sv
`include "rv_defs.svh"

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    // test lengths in instructions
    localparam int N_SETUP = 62;
    localparam int N_ALU   = 160;
    localparam int N_FLOW  = 80;
    localparam int N_NOWR  = 40;
    localparam int N_HS    = 40;
    localparam int N_RST   = 8;
    localparam int N_TOTAL = N_SETUP + N_ALU + N_FLOW + N_NOWR + N_HS + N_RST;
    // one fetch plus execute takes at most 11 cycles
    localparam int TIMEOUT_CYCLES = N_TOTAL * 12 + 50;

    logic     clk;
    logic     rst;
    logic     imem_req;
    word_t    imem_addr;
    logic     imem_ack;
    instr_t   imem_instr;
    logic     wb_valid;
    logic     wb_wen;
    reg_idx_t wb_rd;
    word_t    wb_data;
    word_t    pc;

    // reference model state
    word_t ref_regs [0:`REG_NUM-1];
    word_t ref_pc;

    logic [31:0] rng;
    instr_t      cur_instr;
    word_t       cur_pc;
    int          errors;
    int          test_errors;
    int          checks;
    int          served;
    int          cycles;

    // handshake monitor state
    logic  prev_req;
    logic  prev_ack;
    logic  prev_rst;
    word_t prev_addr;
    int    acks_done;
    int    retired;

    tb_clock_gen clk_gen (.clk(clk));

    rv_core rv_core_i (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_instr (imem_instr),
        .wb_valid   (wb_valid),
        .wb_wen     (wb_wen),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .pc         (pc)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    function automatic reg_idx_t random_rd();
        return reg_idx_t'(rand_below(31) + 1);
    endfunction

    // instruction encoders, one per format
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL};
    endfunction

    // random OP or OP-IMM, legal shift encodings only
    function automatic instr_t alu_instr(input reg_idx_t rd);
        logic [31:0] w;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        instr_t      res;
        w   = rand_word();
        f3  = w[2:0];
        alt = w[3];
        imm = w[26:15];
        if (w[14]) begin
            // only ADD/SUB and SRL/SRA have a bit 30 variant
            if (f3 != F3_ADD_SUB && f3 != F3_SRL_SRA) begin
                alt = 1'b0;
            end
            res = enc_r({1'b0, alt, 5'b0}, w[13:9], w[8:4], f3, rd);
        end else begin
            if (f3 == F3_SLL) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == F3_SRL_SRA) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            res = enc_i(imm, w[8:4], f3, rd, OP_IMM);
        end
        return res;
    endfunction

    // branches, jumps and AUIPC with small even offsets
    function automatic instr_t flow_instr();
        logic [31:0] w;
        int          off;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        instr_t      res;
        w   = rand_word();
        off = int'(w[5:0]) * 2 - 64;
        // equal operands now and then so BEQ and BGE get taken
        rs2 = (w[17:16] == 2'b00) ? w[15:11] : w[22:18];
        f3  = w[25:23];
        // 010 and 011 are not branch codes
        if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = f3 + 3'd2;
        end
        case (w[28:26])
            3'd4, 3'd5: res = enc_j(off[20:0], w[10:6]);
            3'd6:       res = enc_i(off[11:0], w[15:11], 3'b000, w[10:6], rv_isa_pkg::JALR);
            3'd7:       res = enc_u({w[31:29], 17'h0}, w[10:6], AUIPC);
            default:    res = enc_b(off[12:0], rs2, w[15:11], f3);
        endcase
        return res;
    endfunction

    // instructions that must not write, plus reads of x0
    function automatic instr_t nowrite_instr();
        logic [31:0] w;
        int          off;
        reg_idx_t    rd;
        instr_t      res;
        w   = rand_word();
        off = int'(w[12:7]) * 2 - 64;
        rd  = (w[6:2] == 5'd0) ? 5'd1 : w[6:2];
        case (w[1:0])
            2'd0: res = alu_instr(5'd0);
            2'd1: res = enc_b(off[12:0], w[17:13], w[22:18], w[25] ? F3_BNE : F3_BGEU);
            // SYSTEM or FENCE with a live rd field
            2'd2: res = w[26] ? enc_i(w[31:20], w[19:15], w[29:27], rd, SYSTEM)
                              : {w[31:12], rd, 7'b0001111};
            default: res = enc_r(7'h00, 5'd0, 5'd0, F3_OR, rd);
        endcase
        return res;
    endfunction

    // integer ops by the ISA rules
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            F3_ADD_SUB: r = alt ? (a - b) : (a + b);
            F3_SLL:     r = a << b[4:0];
            F3_SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     r = a ^ b;
            F3_OR:      r = a | b;
            F3_AND:     r = a & b;
            default: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
        endcase
        return r;
    endfunction

    // one instruction on the model, returns the expected retire record
    task automatic model_execute(input instr_t w, output logic wen, output reg_idx_t rd,
                                 output word_t data);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_b;
        word_t imm_j;
        word_t nxt;
        logic  taken;
        rd    = w[11:7];
        a     = ref_regs[w[19:15]];
        b     = ref_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        nxt   = ref_pc + 32'd4;
        wen   = 1'b0;
        data  = '0;
        taken = 1'b0;
        case (w[6:0])
            OP: begin
                data = alu_ref(w[14:12], w[30], a, b);
                wen  = 1'b1;
            end
            OP_IMM: begin
                data = alu_ref(w[14:12], w[30] && (w[14:12] == F3_SRL_SRA), a, imm_i);
                wen  = 1'b1;
            end
            LUI: begin
                data = {w[31:12], 12'b0};
                wen  = 1'b1;
            end
            AUIPC: begin
                data = ref_pc + {w[31:12], 12'b0};
                wen  = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                data = ref_pc + 32'd4;
                wen  = 1'b1;
                nxt  = ref_pc + imm_j;
            end
            rv_isa_pkg::JALR: begin
                data = ref_pc + 32'd4;
                wen  = 1'b1;
                nxt  = (a + imm_i) & ~32'd1;
            end
            BRANCH: begin
                case (w[14:12])
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nxt = ref_pc + imm_b;
                end
            end
            default: begin
                // SYSTEM and FENCE only move the pc
            end
        endcase
        if (rd == 5'd0) begin
            wen = 1'b0;
        end
        if (wen) begin
            ref_regs[rd] = data;
        end
        // no traps, fetch address is word aligned
        ref_pc = nxt & ~32'd3;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t instr %h pc %h: %s is %h, expected %h",
                     $time, cur_instr, cur_pc, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic protocol_error(input string msg);
        $display("fetch handshake broken at time %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d instructions, %0d errors", num, name, served, test_errors);
        test_errors = 0;
        served      = 0;
    endtask

    // reset for three cycles, model pc follows
    task automatic apply_reset();
        rst      <= 1'b1;
        imem_ack <= 1'b0;
        repeat (3) @(posedge clk);
        rst    <= 1'b0;
        ref_pc = `RESET_PC;
    endtask

    task automatic check_reset_fetch();
        cur_instr = '0;
        cur_pc    = `RESET_PC;
        while (imem_req !== 1'b1) begin
            @(posedge clk);
        end
        check_value("first fetch address after reset", imem_addr, `RESET_PC);
    endtask

    // serve one word over the handshake, then check its retire
    task automatic run_instr(input instr_t w);
        logic     exp_wen;
        reg_idx_t exp_rd;
        word_t    exp_data;
        int       ack_delay;
        int       release_delay;
        ack_delay     = rand_below(4);
        release_delay = rand_below(4);
        cur_instr     = w;
        cur_pc        = ref_pc;
        while (imem_req !== 1'b1) begin
            @(posedge clk);
        end
        check_value("fetch address", imem_addr, ref_pc);
        repeat (ack_delay) @(posedge clk);
        imem_ack   <= 1'b1;
        imem_instr <= w;
        @(posedge clk);
        // ack held until the core drops req
        while (imem_req !== 1'b0) begin
            @(posedge clk);
        end
        repeat (release_delay) @(posedge clk);
        imem_ack <= 1'b0;
        model_execute(w, exp_wen, exp_rd, exp_data);
        @(posedge clk);
        while (wb_valid !== 1'b1) begin
            @(posedge clk);
        end
        check_value("wb_wen", 32'(wb_wen), 32'(exp_wen));
        check_value("pc after retire", pc, ref_pc);
        if (exp_wen) begin
            check_value("wb_rd", 32'(wb_rd), 32'(exp_rd));
            check_value("wb_data", wb_data, exp_data);
        end
        served++;
    endtask

    // handshake rules, sampled on the rising edge
    always @(posedge clk) begin
        if (!rst && !prev_rst) begin
            if (prev_req && !prev_ack) begin
                assert (imem_req === 1'b1)
                    else protocol_error("imem_req dropped before imem_ack");
            end
            if (prev_req && imem_req) begin
                assert (imem_addr === prev_addr)
                    else protocol_error("imem_addr moved while imem_req was high");
            end
            if (!prev_req && imem_req) begin
                assert (imem_ack === 1'b0)
                    else protocol_error("imem_req raised while imem_ack was still high");
            end
            if (prev_ack && !imem_ack) begin
                assert (acks_done == retired)
                    else protocol_error("a second handshake completed before a retire");
                acks_done++;
            end
            if (wb_valid) begin
                assert (acks_done == retired + 1)
                    else protocol_error("wb_valid without a completed handshake");
                retired++;
            end
        end
        prev_req  = imem_req;
        prev_ack  = imem_ack;
        prev_rst  = rst;
        prev_addr = imem_addr;
    end

    // run limit from the instruction count
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core stopped retiring instructions",
                     cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] w;
        rst         = 1'b1;
        imem_ack    = 1'b0;
        imem_instr  = '0;
        rng         = 32'ha98c1f8f;
        ref_pc      = `RESET_PC;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        served      = 0;
        cycles      = 0;
        acks_done   = 0;
        retired     = 0;
        prev_req    = 1'b0;
        prev_ack    = 1'b0;
        prev_rst    = 1'b1;
        prev_addr   = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            ref_regs[i] = '0;
        end

        apply_reset();
        check_reset_fetch();

        // every register written before any random read
        for (int r = 1; r < `REG_NUM; r++) begin
            w = rand_word();
            run_instr(enc_u(w[31:12], reg_idx_t'(r), LUI));
            run_instr(enc_i(w[11:0], reg_idx_t'(r), F3_ADD_SUB, reg_idx_t'(r), OP_IMM));
        end
        report_test(1, "register setup");

        for (int n = 0; n < N_ALU; n++) begin
            run_instr(alu_instr(random_rd()));
        end
        report_test(2, "arithmetic and logic");

        for (int n = 0; n < N_FLOW; n++) begin
            run_instr(flow_instr());
        end
        report_test(3, "control flow");

        for (int n = 0; n < N_NOWR; n++) begin
            run_instr(nowrite_instr());
        end
        report_test(4, "x0 and no-write instructions");

        for (int n = 0; n < N_HS; n++) begin
            run_instr(alu_instr(random_rd()));
        end
        // monitor counts the last retire on the edge just passed
        @(posedge clk);
        assert (acks_done == retired)
            else protocol_error("handshake and retire counts differ");
        report_test(5, "handshake");

        // reset in the middle of the run, registers keep their values
        apply_reset();
        check_reset_fetch();
        for (int n = 0; n < N_RST; n++) begin
            run_instr(alu_instr(random_rd()));
        end
        report_test(6, "reset");

        // let the monitor see the last retire
        @(posedge clk);
        $display("%0d instructions, %0d checks, %0d errors", N_TOTAL, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule
